// ==== list.f ====
+incdir+sim
rtl/rename_cfg_pkg.sv
rtl/rename_types_pkg.sv
rtl/retire_if.sv
rtl/victim_free_list.sv
rtl/free_list.sv
rtl/map_table.sv
rtl/arch_map_table.sv
rtl/reorder_buffer.sv
rtl/rename_top.sv
sim/rename_tb.sv

// ==== rtl/arch_map_table.sv ====
`timescale 1ns/1ps
`default_nettype none

module arch_map_table
    import rename_cfg_pkg::*, rename_types_pkg::*;
(
    input  wire logic                          clk_i,
    input  wire logic                          rst_i,
    retire_if.listener                         rt,
    output tag_t [ARCH_REG_NUM-1:0]            arch_map_o
);

    // Committed arch-to-physical map
    tag_t [ARCH_REG_NUM-1:0] arch_map_q;

    // Full table out for flush restore
    assign arch_map_o = arch_map_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            // Identity mapping
            for (int a = 0; a < ARCH_REG_NUM; a++) begin
                arch_map_q[a] <= TAG_W'(a);
            end
        end else begin
            // Lane 0 first, younger lane overrides on same arch_dst
            for (int l = 0; l < RT_NUM; l++) begin
                if (rt.lane[l].wr_en) begin
                    arch_map_q[rt.lane[l].arch_dst] <= rt.lane[l].tag;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/free_list.sv ====
`timescale 1ns/1ps
`default_nettype none

module free_list
    import rename_cfg_pkg::*, rename_types_pkg::*;
(
    input  wire logic                          clk_i,
    input  wire logic                          rst_i,
    input  wire logic                          flush_i,
    input  wire logic [1:0]                    alloc_num_i,
    retire_if.listener                         rt,
    input  wire fl_entry_t [FL_ENTRY_NUM-1:0]  vfl_fl_i,
    output tag_t [DP_NUM-1:0]                  alloc_tag_o,
    output logic [FL_W:0]                      free_cnt_o
);

    // Heads carry one wrap bit above the slot index
    logic [FL_W:0] spec_head_q;
    logic [FL_W:0] rt_head_q;
    logic [FL_W:0] rt_num;
    logic [FL_W:0] head_dist;

    // Retiring lanes this cycle
    always_comb begin
        rt_num = '0;
        for (int l = 0; l < RT_NUM; l++) begin
            rt_num = rt_num + (FL_W + 1)'(rt.lane[l].wr_en);
        end
    end

    // Slots between retired and speculative head are in flight
    assign head_dist  = spec_head_q - rt_head_q;
    assign free_cnt_o = (FL_W + 1)'(FL_ENTRY_NUM) - head_dist;

    // Allocation reads consecutive slots from the speculative head,
    // index wraps inside the slot array
    always_comb begin
        for (int d = 0; d < DP_NUM; d++) begin
            alloc_tag_o[d] = vfl_fl_i[spec_head_q[FL_W-1:0] + FL_W'(d)].tag;
        end
    end

    // ==============================
    // Head pointers
    // ==============================

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            spec_head_q <= '0;
            rt_head_q   <= '0;
        end else begin
            // Retired head follows the ROB retirement count
            rt_head_q <= rt_head_q + rt_num;
            if (flush_i) begin
                // Drop every in-flight allocation
                spec_head_q <= rt_head_q + rt_num;
            end else begin
                spec_head_q <= spec_head_q + (FL_W + 1)'(alloc_num_i);
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/map_table.sv ====
`timescale 1ns/1ps
`default_nettype none

module map_table
    import rename_cfg_pkg::*, rename_types_pkg::*;
(
    input  wire logic                          clk_i,
    input  wire logic                          rst_i,
    input  wire logic                          flush_i,
    input  wire logic [DP_NUM-1:0]             dp_valid_i,
    input  wire arch_t [DP_NUM-1:0]            dp_arch_dst_i,
    input  wire arch_t [DP_NUM-1:0]            dp_arch_src_i,
    input  wire tag_t [DP_NUM-1:0]             dp_tag_i,
    input  wire tag_t [ARCH_REG_NUM-1:0]       arch_map_i,
    output tag_t [DP_NUM-1:0]                  dp_tag_old_o,
    output tag_t [DP_NUM-1:0]                  dp_src_tag_o
);

    // Speculative arch-to-physical map
    tag_t [ARCH_REG_NUM-1:0] map_q;

    // Lookup with bypass from older lanes in the bundle
    always_comb begin
        for (int d = 0; d < DP_NUM; d++) begin
            dp_tag_old_o[d] = map_q[dp_arch_dst_i[d]];
            dp_src_tag_o[d] = map_q[dp_arch_src_i[d]];
            // Youngest older writer wins
            for (int o = 0; o < d; o++) begin
                if (dp_valid_i[o] && (dp_arch_dst_i[o] == dp_arch_dst_i[d])) begin
                    dp_tag_old_o[d] = dp_tag_i[o];
                end
                if (dp_valid_i[o] && (dp_arch_dst_i[o] == dp_arch_src_i[d])) begin
                    dp_src_tag_o[d] = dp_tag_i[o];
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            // Identity mapping
            for (int a = 0; a < ARCH_REG_NUM; a++) begin
                map_q[a] <= TAG_W'(a);
            end
        end else if (flush_i) begin
            // Back to retirement state
            map_q <= arch_map_i;
        end else begin
            // Lane order, so the younger lane lands last
            for (int d = 0; d < DP_NUM; d++) begin
                if (dp_valid_i[d]) begin
                    map_q[dp_arch_dst_i[d]] <= dp_tag_i[d];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/rename_cfg_pkg.sv ====
`default_nettype none

package rename_cfg_pkg;

    // Pipeline widths
    localparam int DP_NUM = 2;
    localparam int RT_NUM = 2;
    localparam int CP_NUM = 2;

    // Register file sizes
    localparam int ARCH_REG_NUM = 32;
    localparam int PHY_REG_NUM  = 64;

    // One free slot per physical register beyond the architectural set
    localparam int FL_ENTRY_NUM = PHY_REG_NUM - ARCH_REG_NUM;

    // In-flight window
    localparam int ROB_NUM = 16;

    // Derived index widths
    localparam int TAG_W  = $clog2(PHY_REG_NUM);
    localparam int ARCH_W = $clog2(ARCH_REG_NUM);
    localparam int ROB_W  = $clog2(ROB_NUM);
    localparam int FL_W   = $clog2(FL_ENTRY_NUM);

endpackage

`default_nettype wire

// ==== rtl/rename_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rename_top
    import rename_cfg_pkg::*, rename_types_pkg::*;
(
    input  wire logic                          clk_i,
    input  wire logic                          rst_i,
    input  wire logic                          flush_i,
    input  wire logic [DP_NUM-1:0]             dp_valid_i,
    input  wire arch_t [DP_NUM-1:0]            dp_arch_dst_i,
    input  wire arch_t [DP_NUM-1:0]            dp_arch_src_i,
    input  wire logic [CP_NUM-1:0]             cp_valid_i,
    input  wire rob_idx_t [CP_NUM-1:0]         cp_rob_idx_i,
    output logic                               dp_ready_o,
    output tag_t [DP_NUM-1:0]                  dp_tag_o,
    output tag_t [DP_NUM-1:0]                  dp_tag_old_o,
    output tag_t [DP_NUM-1:0]                  dp_src_tag_o,
    output rob_idx_t [DP_NUM-1:0]              dp_rob_idx_o,
    output logic [RT_NUM-1:0]                  rt_valid_o,
    output arch_t [RT_NUM-1:0]                 rt_arch_o,
    output tag_t [RT_NUM-1:0]                  rt_tag_o,
    output tag_t [RT_NUM-1:0]                  rt_tag_old_o
);

    // ==============================
    // Internal nets
    // ==============================

    retire_if rt_bus ();

    fl_entry_t [FL_ENTRY_NUM-1:0] vfl_fl;
    tag_t [ARCH_REG_NUM-1:0]      arch_map;
    tag_t [DP_NUM-1:0]            alloc_tag;
    logic [FL_W:0]                fl_free_cnt;
    logic [ROB_W:0]               rob_free_cnt;
    rob_idx_t                     rob_tail;
    logic [DP_NUM-1:0]            dp_fire;
    logic [1:0]                   alloc_num;

    // ==============================
    // Dispatch control
    // ==============================

    // Room for a full bundle, registered counts only
    assign dp_ready_o = (fl_free_cnt >= (FL_W + 1)'(DP_NUM))
                     && (rob_free_cnt >= (ROB_W + 1)'(DP_NUM))
                     && !flush_i;

    assign dp_fire = dp_valid_i & {DP_NUM{dp_ready_o}};

    // One tag per accepted lane
    always_comb begin
        alloc_num = '0;
        for (int d = 0; d < DP_NUM; d++) begin
            alloc_num = alloc_num + 2'(dp_fire[d]);
        end
    end

    // New tags and ROB slots in lane order
    always_comb begin
        for (int d = 0; d < DP_NUM; d++) begin
            dp_tag_o[d]     = alloc_tag[d];
            dp_rob_idx_o[d] = rob_tail + ROB_W'(d);
        end
    end

    // Retire bus out to plain ports
    always_comb begin
        for (int l = 0; l < RT_NUM; l++) begin
            rt_valid_o[l]   = rt_bus.lane[l].wr_en;
            rt_arch_o[l]    = rt_bus.lane[l].arch_dst;
            rt_tag_o[l]     = rt_bus.lane[l].tag;
            rt_tag_old_o[l] = rt_bus.lane[l].tag_old;
        end
    end

    // ==============================
    // Blocks
    // ==============================

    victim_free_list u_vfl (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .rt       (rt_bus),
        .vfl_fl_o (vfl_fl)
    );

    free_list u_fl (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .flush_i     (flush_i),
        .alloc_num_i (alloc_num),
        .rt          (rt_bus),
        .vfl_fl_i    (vfl_fl),
        .alloc_tag_o (alloc_tag),
        .free_cnt_o  (fl_free_cnt)
    );

    map_table u_map (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .flush_i       (flush_i),
        .dp_valid_i    (dp_fire),
        .dp_arch_dst_i (dp_arch_dst_i),
        .dp_arch_src_i (dp_arch_src_i),
        .dp_tag_i      (alloc_tag),
        .arch_map_i    (arch_map),
        .dp_tag_old_o  (dp_tag_old_o),
        .dp_src_tag_o  (dp_src_tag_o)
    );

    arch_map_table u_amap (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .rt         (rt_bus),
        .arch_map_o (arch_map)
    );

    reorder_buffer u_rob (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .flush_i       (flush_i),
        .dp_valid_i    (dp_fire),
        .dp_arch_dst_i (dp_arch_dst_i),
        .dp_tag_i      (alloc_tag),
        .dp_tag_old_i  (dp_tag_old_o),
        .cp_valid_i    (cp_valid_i),
        .cp_rob_idx_i  (cp_rob_idx_i),
        .rt            (rt_bus),
        .tail_o        (rob_tail),
        .free_cnt_o    (rob_free_cnt)
    );

endmodule

`default_nettype wire

// ==== rtl/rename_types_pkg.sv ====
`default_nettype none

package rename_types_pkg;

    import rename_cfg_pkg::*;

    // Physical register number
    typedef logic [TAG_W-1:0]  tag_t;
    // Architectural register number
    typedef logic [ARCH_W-1:0] arch_t;
    // Position in the reorder buffer
    typedef logic [ROB_W-1:0]  rob_idx_t;

    // One free-list slot
    typedef struct packed {
        tag_t tag;
    } fl_entry_t;

    // Reorder buffer record, 18 bits
    typedef struct packed {
        arch_t arch_dst;
        tag_t  tag;
        tag_t  tag_old;
        logic  done;
    } rob_entry_t;

    // One lane of the retirement bus, 18 bits
    typedef struct packed {
        logic  wr_en;
        arch_t arch_dst;
        tag_t  tag;
        tag_t  tag_old;
    } rt_lane_t;

endpackage

`default_nettype wire

// ==== rtl/reorder_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer
    import rename_cfg_pkg::*, rename_types_pkg::*;
(
    input  wire logic                          clk_i,
    input  wire logic                          rst_i,
    input  wire logic                          flush_i,
    input  wire logic [DP_NUM-1:0]             dp_valid_i,
    input  wire arch_t [DP_NUM-1:0]            dp_arch_dst_i,
    input  wire tag_t [DP_NUM-1:0]             dp_tag_i,
    input  wire tag_t [DP_NUM-1:0]             dp_tag_old_i,
    input  wire logic [CP_NUM-1:0]             cp_valid_i,
    input  wire rob_idx_t [CP_NUM-1:0]         cp_rob_idx_i,
    retire_if.rob                              rt,
    output rob_idx_t                           tail_o,
    output logic [ROB_W:0]                     free_cnt_o
);

    // ==============================
    // State
    // ==============================

    // Record storage
    rob_entry_t rob_q [ROB_NUM];

    // Circular pointers and occupancy
    rob_idx_t       head_q;
    rob_idx_t       tail_q;
    logic [ROB_W:0] cnt_q;

    // Per-cycle movement
    logic [RT_NUM-1:0] rt_fire;
    logic [ROB_W:0]    dp_num;
    logic [ROB_W:0]    rt_num;

    assign tail_o     = tail_q;
    assign free_cnt_o = (ROB_W + 1)'(ROB_NUM) - cnt_q;

    // ==============================
    // Retire selection
    // ==============================

    // Done entries at the head, in order, stop at first gap
    always_comb begin
        rob_idx_t slot;
        logic     take;
        take = !flush_i;
        for (int l = 0; l < RT_NUM; l++) begin
            slot = head_q + ROB_W'(l);
            take = take && (cnt_q > (ROB_W + 1)'(l)) && rob_q[slot].done;
            rt_fire[l]          = take;
            rt.lane[l].wr_en    = take;
            rt.lane[l].arch_dst = rob_q[slot].arch_dst;
            rt.lane[l].tag      = rob_q[slot].tag;
            rt.lane[l].tag_old  = rob_q[slot].tag_old;
        end
    end

    // Lane counts
    always_comb begin
        dp_num = '0;
        rt_num = '0;
        for (int d = 0; d < DP_NUM; d++) begin
            dp_num = dp_num + (ROB_W + 1)'(dp_valid_i[d]);
        end
        for (int l = 0; l < RT_NUM; l++) begin
            rt_num = rt_num + (ROB_W + 1)'(rt_fire[l]);
        end
    end

    // ==============================
    // Pointer update
    // ==============================

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            head_q <= '0;
            tail_q <= '0;
            cnt_q  <= '0;
        end else if (flush_i) begin
            // Empty the window
            head_q <= '0;
            tail_q <= '0;
            cnt_q  <= '0;
        end else begin
            head_q <= head_q + rt_num[ROB_W-1:0];
            tail_q <= tail_q + dp_num[ROB_W-1:0];
            cnt_q  <= cnt_q + dp_num - rt_num;
        end
    end

    // Record writes
    always_ff @(posedge clk_i) begin
        // Lanes append from the tail
        for (int d = 0; d < DP_NUM; d++) begin
            if (dp_valid_i[d]) begin
                rob_q[tail_q + ROB_W'(d)] <= '{
                    arch_dst: dp_arch_dst_i[d],
                    tag:      dp_tag_i[d],
                    tag_old:  dp_tag_old_i[d],
                    done:     1'b0
                };
            end
        end
        // Completion by index
        for (int c = 0; c < CP_NUM; c++) begin
            if (cp_valid_i[c]) begin
                rob_q[cp_rob_idx_i[c]].done <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/retire_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// Retirement bus from the ROB to the blocks
// that track retirement-point state
interface retire_if
    import rename_cfg_pkg::*, rename_types_pkg::*;
();

    // Lane 0 is always the older instruction
    // Lanes fill from 0 upward, wr_en is a one-cycle strobe
    rt_lane_t [RT_NUM-1:0] lane;

    // ROB side drives the lanes
    modport rob (
        output lane
    );

    // Victim list, free list and arch map only observe
    modport listener (
        input lane
    );

endinterface

`default_nettype wire

// ==== rtl/victim_free_list.sv ====
`timescale 1ns/1ps
`default_nettype none

module victim_free_list
    import rename_cfg_pkg::*, rename_types_pkg::*;
(
    input  wire logic                          clk_i,
    input  wire logic                          rst_i,
    retire_if.listener                         rt,
    output fl_entry_t [FL_ENTRY_NUM-1:0]       vfl_fl_o
);

    // ==============================
    // Slot storage
    // ==============================

    // Free list as seen at the retirement point
    fl_entry_t [FL_ENTRY_NUM-1:0] vfl_q;

    // ==============================
    // Forwarded view
    // ==============================

    // Swap applied combinationally so the free list
    // allocates from this cycle's retirements already
    always_comb begin
        vfl_fl_o = vfl_q;
        for (int s = 0; s < FL_ENTRY_NUM; s++) begin
            for (int l = 0; l < RT_NUM; l++) begin
                // CAM hit: retiring tag lives in this slot
                if (rt.lane[l].wr_en && (rt.lane[l].tag == vfl_q[s].tag)) begin
                    vfl_fl_o[s].tag = rt.lane[l].tag_old;
                end
            end
        end
    end

    // ==============================
    // Retirement swap
    // ==============================

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            // Slot i starts with the first tag past the arch set
            for (int s = 0; s < FL_ENTRY_NUM; s++) begin
                vfl_q[s].tag <= TAG_W'(ARCH_REG_NUM + s);
            end
        end else begin
            // New tag out, freed old tag in
            vfl_q <= vfl_fl_o;
        end
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build and run the rename testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f list.f --top-module rename_tb \
    -o rename_sim > build.log 2>&1 \
    && ./obj_dir/rename_sim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "Run did not complete"; exit 1; }
cat sim.log
grep -q "Simulation failed" sim.log && exit 1 || exit 0

// ==== sim/rename_ref.svh ====
`ifndef RENAME_REF_SVH
`define RENAME_REF_SVH

// ==============================
// Reference state
// ==============================

// Free slots with speculative and retired heads, heads wrap at 2x slots
int slot_q [FL_ENTRY_NUM];
int spec_head;
int rt_head;

// Speculative and committed maps
int smap [ARCH_REG_NUM];
int amap [ARCH_REG_NUM];

// ROB records and window
int rob_dst [ROB_NUM];
int rob_tag [ROB_NUM];
int rob_old [ROB_NUM];
bit rob_done [ROB_NUM];
int rob_head;
int rob_cnt;

// Retirements seen in the last stepped cycle
int last_rt_n;

// Random source
logic [15:0] lfsr_q = 16'd16;

// State after reset: identity maps, slot i holds 32 plus i
task automatic reset_model();
    for (int s = 0; s < FL_ENTRY_NUM; s++) begin
        slot_q[s] = ARCH_REG_NUM + s;
    end
    for (int a = 0; a < ARCH_REG_NUM; a++) begin
        smap[a] = a;
        amap[a] = a;
    end
    spec_head = 0;
    rt_head   = 0;
    rob_head  = 0;
    rob_cnt   = 0;
    last_rt_n = 0;
endtask

// Free tags between the heads
function automatic int free_tags();
    return FL_ENTRY_NUM - ((spec_head - rt_head + 2 * FL_ENTRY_NUM) % (2 * FL_ENTRY_NUM));
endfunction

// Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] next_lfsr(logic [15:0] cur);
    return cur[0] ? ((cur >> 1) ^ 16'hB400) : (cur >> 1);
endfunction

// One LFSR step per bit taken
function automatic int take_bits(int n);
    int v;
    v = 0;
    for (int b = 0; b < n; b++) begin
        lfsr_q = next_lfsr(lfsr_q);
        v = (v << 1) | int'(lfsr_q[0]);
    end
    return v;
endfunction

`endif

// ==== sim/rename_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rename_tb
    import rename_cfg_pkg::*;
();

    logic                         clk_i = 1'b0;
    logic                         rst_i;
    logic                         flush_i;
    logic [DP_NUM-1:0]            dp_valid_i;
    logic [DP_NUM-1:0][ARCH_W-1:0] dp_arch_dst_i;
    logic [DP_NUM-1:0][ARCH_W-1:0] dp_arch_src_i;
    logic [CP_NUM-1:0]            cp_valid_i;
    logic [CP_NUM-1:0][ROB_W-1:0] cp_rob_idx_i;
    wire                          dp_ready_o;
    wire [DP_NUM-1:0][TAG_W-1:0]  dp_tag_o;
    wire [DP_NUM-1:0][TAG_W-1:0]  dp_tag_old_o;
    wire [DP_NUM-1:0][TAG_W-1:0]  dp_src_tag_o;
    wire [DP_NUM-1:0][ROB_W-1:0]  dp_rob_idx_o;
    wire [RT_NUM-1:0]             rt_valid_o;
    wire [RT_NUM-1:0][ARCH_W-1:0] rt_arch_o;
    wire [RT_NUM-1:0][TAG_W-1:0]  rt_tag_o;
    wire [RT_NUM-1:0][TAG_W-1:0]  rt_tag_old_o;

    // Stimulus for the next cycle
    logic [DP_NUM-1:0] dv;
    int dst [DP_NUM];
    int src [DP_NUM];
    logic [CP_NUM-1:0] cpv;
    int cpi [CP_NUM];
    logic flush_d;

    // Observed tags of the last cycle
    int obs_tag [DP_NUM];
    int obs_old [DP_NUM];
    int obs_src [DP_NUM];

    string cur_test;
    int test_errs;
    int tests_passed = 0;
    int tests_failed = 0;

    `include "rename_ref.svh"

    rename_top dut (.*);

    // 40 ns period
    always #20 clk_i = ~clk_i;

    task automatic check_val(string what, int exp, int act);
        assert (exp == act) else begin
            $display("MISMATCH %s %s: expected %0d actual %0d", cur_test, what, exp, act);
            test_errs++;
        end
    endtask

    // Tag held by the speculative map or by an in-flight old tag
    function automatic bit tag_is_live(int tag, int skip);
        bit live;
        live = 1'b0;
        for (int a = 0; a < ARCH_REG_NUM; a++) begin
            if (smap[a] == tag) live = 1'b1;
        end
        // Entries retiring this cycle release their old tag
        for (int k = skip; k < rob_cnt; k++) begin
            if (rob_old[(rob_head + k) % ROB_NUM] == tag) live = 1'b1;
        end
        return live;
    endfunction

    // ==============================
    // One cycle: drive, check, step model
    // ==============================

    task automatic run_cycle();
        int fwd [FL_ENTRY_NUM];
        bit rt_en [RT_NUM];
        int tag_exp [DP_NUM];
        int old_exp [DP_NUM];
        int src_exp [DP_NUM];
        bit fire [DP_NUM];
        bit ready_exp;
        int tail;
        int e;
        int nrt;
        flush_i    = flush_d;
        dp_valid_i = dv;
        cp_valid_i = cpv;
        for (int d = 0; d < DP_NUM; d++) begin
            dp_arch_dst_i[d] = ARCH_W'(dst[d]);
            dp_arch_src_i[d] = ARCH_W'(src[d]);
        end
        for (int c = 0; c < CP_NUM; c++) begin
            cp_rob_idx_i[c] = ROB_W'(cpi[c]);
        end
        #1;
        tail = (rob_head + rob_cnt) % ROB_NUM;
        fwd = slot_q;
        nrt = 0;
        // Retire lanes from done head entries
        for (int l = 0; l < RT_NUM; l++) begin
            e = (rob_head + l) % ROB_NUM;
            rt_en[l] = !flush_d && rob_cnt > l && rob_done[e] && (l == 0 || rt_en[l - 1]);
            check_val("rt_valid", rt_en[l], rt_valid_o[l]);
            if (rt_en[l]) begin
                nrt++;
                check_val("rt_arch", rob_dst[e], rt_arch_o[l]);
                check_val("rt_tag", rob_tag[e], rt_tag_o[l]);
                check_val("rt_tag_old", rob_old[e], rt_tag_old_o[l]);
                // Retired tag leaves its slot, old tag takes its place
                for (int s = 0; s < FL_ENTRY_NUM; s++) begin
                    if (slot_q[s] == rob_tag[e]) fwd[s] = rob_old[e];
                end
            end
        end
        ready_exp = free_tags() >= 2 && (ROB_NUM - rob_cnt) >= 2 && !flush_d;
        check_val("dp_ready", ready_exp, dp_ready_o);
        for (int d = 0; d < DP_NUM; d++) begin
            fire[d]    = dv[d] && ready_exp;
            tag_exp[d] = fwd[(spec_head + d) % FL_ENTRY_NUM];
            old_exp[d] = smap[dst[d]];
            src_exp[d] = smap[src[d]];
            if (d == 1 && fire[0] && dst[0] == dst[1]) old_exp[d] = tag_exp[0];
            if (d == 1 && fire[0] && dst[0] == src[1]) src_exp[d] = tag_exp[0];
            obs_tag[d] = int'(dp_tag_o[d]);
            obs_old[d] = int'(dp_tag_old_o[d]);
            obs_src[d] = int'(dp_src_tag_o[d]);
            if (fire[d]) begin
                check_val("dp_tag", tag_exp[d], dp_tag_o[d]);
                check_val("dp_tag_old", old_exp[d], dp_tag_old_o[d]);
                check_val("dp_src_tag", src_exp[d], dp_src_tag_o[d]);
                check_val("dp_rob_idx", (tail + d) % ROB_NUM, dp_rob_idx_o[d]);
                // Allocated tag must not be mapped or awaiting release
                assert (!tag_is_live(int'(dp_tag_o[d]), nrt)
                        && !(d == 1 && fire[0] && dp_tag_o[1] == dp_tag_o[0])) else begin
                    $display("%s: tag %0d allocated while still live", cur_test,
                             dp_tag_o[d]);
                    test_errs++;
                end
            end
        end
        // Step the reference state
        slot_q = fwd;
        for (int l = 0; l < RT_NUM; l++) begin
            e = (rob_head + l) % ROB_NUM;
            if (rt_en[l]) amap[rob_dst[e]] = rob_tag[e];
        end
        rob_head  = (rob_head + nrt) % ROB_NUM;
        rob_cnt   = rob_cnt - nrt;
        rt_head   = (rt_head + nrt) % (2 * FL_ENTRY_NUM);
        last_rt_n = nrt;
        if (flush_d) begin
            spec_head = rt_head;
            smap      = amap;
            rob_head  = 0;
            rob_cnt   = 0;
        end else begin
            for (int d = 0; d < DP_NUM; d++) begin
                if (fire[d]) begin
                    e = (tail + d) % ROB_NUM;
                    smap[dst[d]] = tag_exp[d];
                    rob_dst[e]   = dst[d];
                    rob_tag[e]   = tag_exp[d];
                    rob_old[e]   = old_exp[d];
                    rob_done[e]  = 1'b0;
                    rob_cnt++;
                    spec_head = (spec_head + 1) % (2 * FL_ENTRY_NUM);
                end
            end
            for (int c = 0; c < CP_NUM; c++) begin
                if (cpv[c]) rob_done[cpi[c]] = 1'b1;
            end
        end
        @(posedge clk_i);
        @(negedge clk_i);
    endtask

    // Random bundle and completions over live entries only
    task automatic pick_inputs(bit allow_dp, bit allow_cp);
        int n;
        n = take_bits(2);
        dv = !allow_dp ? 2'b00 : (n == 0) ? 2'b00 : (n == 1) ? 2'b01 : 2'b11;
        for (int d = 0; d < DP_NUM; d++) begin
            dst[d] = take_bits(ARCH_W);
            src[d] = take_bits(ARCH_W);
        end
        cpv = '0;
        flush_d = 1'b0;
        for (int c = 0; c < CP_NUM; c++) begin
            if (allow_cp && rob_cnt > 0 && take_bits(1) == 1) begin
                cpv[c] = 1'b1;
                cpi[c] = (rob_head + take_bits(ROB_W) % rob_cnt) % ROB_NUM;
            end
        end
    endtask

    // Complete and retire everything in flight
    task automatic drain_rob();
        int guard;
        guard = 0;
        while (rob_cnt > 0 && guard < 300) begin
            pick_inputs(1'b0, 1'b1);
            run_cycle();
            guard++;
        end
        if (rob_cnt > 0) begin
            $display("%s: timeout, ROB did not drain", cur_test);
            test_errs++;
        end
    endtask

    task automatic start_test(string name);
        cur_test  = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        if (test_errs == 0) begin
            tests_passed++;
            $display("Test %s: ok", cur_test);
        end else begin
            tests_failed++;
            $display("Test %s: %0d errors", cur_test, test_errs);
        end
    endtask

    // ==============================
    // Test sequence
    // ==============================

    initial begin
        int guard;
        rst_i = 1'b1;
        flush_i = 1'b0;
        dp_valid_i = '0;
        dp_arch_dst_i = '0;
        dp_arch_src_i = '0;
        cp_valid_i = '0;
        cp_rob_idx_i = '0;
        dv = '0;
        cpv = '0;
        flush_d = 1'b0;
        for (int d = 0; d < DP_NUM; d++) begin
            dst[d] = 0;
            src[d] = 0;
        end
        for (int c = 0; c < CP_NUM; c++) begin
            cpi[c] = 0;
        end
        repeat (10) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;
        reset_model();

        start_test("reset_state");
        // Idle cycles, ready high and nothing retiring
        repeat (3) run_cycle();
        dv = 2'b11;
        dst = '{3, 5};
        src = '{7, 9};
        run_cycle();
        check_val("first tag", 32, obs_tag[0]);
        check_val("second tag", 33, obs_tag[1]);
        check_val("first tag_old", 3, obs_old[0]);
        dst = '{11, 12};
        run_cycle();
        check_val("third tag", 34, obs_tag[0]);
        drain_rob();
        end_test();

        start_test("bundle_bypass");
        // Four tags went out in the reset test, slot 4 is next
        dv = 2'b11;
        dst = '{6, 6};
        src = '{1, 2};
        run_cycle();
        check_val("same dst old", 36, obs_old[1]);
        dst = '{8, 10};
        src = '{4, 8};
        run_cycle();
        check_val("src bypass", 38, obs_src[1]);
        drain_rob();
        end_test();

        start_test("in_order_retire");
        repeat (40) begin
            pick_inputs(1'b1, 1'b1);
            run_cycle();
        end
        drain_rob();
        end_test();

        start_test("tag_recycle");
        repeat (60) begin
            pick_inputs(1'b1, 1'b1);
            run_cycle();
        end
        drain_rob();
        end_test();

        start_test("flush_recovery");
        repeat (4) begin
            repeat (take_bits(3) + 4) begin
                pick_inputs(1'b1, 1'b1);
                run_cycle();
            end
            // Flush right after a cycle that retired
            guard = 0;
            last_rt_n = 0;
            while (last_rt_n == 0 && guard < 60) begin
                pick_inputs(1'b1, 1'b1);
                run_cycle();
                guard++;
            end
            if (last_rt_n == 0) begin
                $display("%s: timeout, no retirement before flush", cur_test);
                test_errs++;
            end
            pick_inputs(1'b1, 1'b0);
            flush_d = 1'b1;
            run_cycle();
            pick_inputs(1'b1, 1'b0);
            dv = 2'b11;
            run_cycle();
        end
        drain_rob();
        end_test();

        start_test("back_pressure");
        guard = 0;
        dv = 2'b11;
        cpv = '0;
        while (dp_ready_o && guard < 40) begin
            dst = '{take_bits(ARCH_W), take_bits(ARCH_W)};
            run_cycle();
            guard++;
        end
        if (dp_ready_o) begin
            $display("%s: timeout, dp_ready never fell", cur_test);
            test_errs++;
        end
        run_cycle();
        drain_rob();
        guard = 0;
        dv = '0;
        cpv = '0;
        while (!dp_ready_o && guard < 20) begin
            run_cycle();
            guard++;
        end
        if (!dp_ready_o) begin
            $display("%s: timeout, dp_ready did not rise", cur_test);
            test_errs++;
        end
        end_test();

        $display("Tests passed %0d, failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
